//--- files.f
+incdir+logic
logic/snes_pkg.sv
logic/pad_sequencer.sv
logic/pad_shifter.sv
logic/button_regs.sv
logic/snes_reader.sv
dv/snes_pad_model.sv
dv/tb_snes_reader.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_snes_reader
FILELIST = files.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/tb_snes_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "snes_params.svh"

module tb_snes_reader;

    import snes_pkg::*;

    localparam int N_FRAMES = 20;
    localparam int N_WORDS  = N_FRAMES + 4;

    logic        clk = 1'b0;
    logic        aresetn;
    logic [3:0]  araddr;
    logic        arvalid;
    wire         arready;
    wire  [31:0] rdata;
    wire  [1:0]  rresp;
    wire         rvalid;
    logic        rready;
    wire         pad_latch;
    wire         pad_clk;
    wire         pad0_data;
    wire         pad1_data;

    logic [31:0]     lfsr_q = 32'h851a84dd;
    logic [15:0]     words0 [0:N_WORDS-1];
    logic [15:0]     words1 [0:N_WORDS-1];
    pad_buttons_u    exp0   [0:N_WORDS-1];
    pad_buttons_u    exp1   [0:N_WORDS-1];
    int              latch_rises = 0;
    int              latch_falls = 0;

    always #4 clk = ~clk;

    snes_reader UUT (
        .clk       (clk),
        .aresetn   (aresetn),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .pad_latch (pad_latch),
        .pad_clk   (pad_clk),
        .pad0_data (pad0_data),
        .pad1_data (pad1_data)
    );

    // Frame n loads words[n]
    snes_pad_model u_pad_model0 (
        .latch   (pad_latch),
        .pad_clk (pad_clk),
        .word    (words0[latch_falls + 1]),
        .data    (pad0_data)
    );

    snes_pad_model u_pad_model1 (
        .latch   (pad_latch),
        .pad_clk (pad_clk),
        .word    (words1[latch_falls + 1]),
        .data    (pad1_data)
    );

    always @(posedge pad_latch) begin
        latch_rises <= latch_rises + 1;
    end

    // The X to 0 step in reset is no frame
    always @(negedge pad_latch) begin
        if (latch_rises > latch_falls) begin
            latch_falls <= latch_falls + 1;
        end
    end

    // --------------------------------------------------
    // Random bits and error reporting
    // --------------------------------------------------

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            value  = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic value_error(input string msg);
        abort_run($sformatf("FAILED at %0t ns: %s", $time, msg));
    endtask

    task automatic check_pads(input pad_buttons_u got, input pad_buttons_u exp,
                              input string what);
        if (got !== exp) begin
            value_error($sformatf("%s is %03h, expected %03h", what, got.raw, exp.raw));
        end
    endtask

    task automatic check_count(input logic [15:0] got, input logic [15:0] exp,
                               input string what);
        if (got !== exp) begin
            value_error($sformatf("%s is %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_resp(input axil_resp_e got, input axil_resp_e exp, input string what);
        if (got !== exp) begin
            value_error($sformatf("%s is %02b, expected %02b", what, got, exp));
        end
    endtask

    task automatic check_data(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            value_error($sformatf("%s is %08h, expected %08h", what, got, exp));
        end
    endtask

    task automatic check_arready(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_error($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    // --------------------------------------------------
    // AXI-Lite reads
    // --------------------------------------------------

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output axil_resp_e resp);
        logic [31:0] held_data;
        logic [1:0]  held_resp;
        logic        ready;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) begin
            @(negedge clk);
        end
        @(negedge clk);
        arvalid = 1'b0;
        check_arready(arready, 1'b0, "arready after AR transfer");
        while (!rvalid) begin
            @(negedge clk);
        end
        held_data = rdata;
        held_resp = rresp;
        // Payload must hold through random stalls until the transfer
        do begin
            ready  = (rand_bits(1) != 0);
            rready = ready;
            @(negedge clk);
            if (!ready) begin
                if (!rvalid) begin
                    abort_run("rvalid fell during a read stall before the transfer");
                end
                check_arready(arready, 1'b0, "arready under stall");
                check_data(rdata, held_data, "rdata under stall");
                check_resp(axil_resp_e'(rresp), axil_resp_e'(held_resp), "rresp under stall");
            end
        end while (!ready);
        check_arready(arready, 1'b1, "arready after R transfer");
        rready = 1'b0;
        data   = held_data;
        resp   = axil_resp_e'(held_resp);
    endtask

    task automatic check_read(input logic [3:0] addr, input int frame);
        logic [31:0]  data;
        axil_resp_e   resp;
        pad_buttons_u got0;
        pad_buttons_u got1;
        axi_read(addr, data, resp);
        case (addr)
            `SNES_ADDR_PADS: begin
                check_resp(resp, OKAY, "pads response");
                got0.raw = data[`SNES_BTNS-1:0];
                got1.raw = data[2*`SNES_BTNS-1:`SNES_BTNS];
                check_pads(got0, exp0[frame], "pad0 field");
                check_pads(got1, exp1[frame], "pad1 field");
                check_data(data & 32'hff00_0000, 32'h0, "pads word upper bits");
            end
            `SNES_ADDR_FRAMES: begin
                check_resp(resp, OKAY, "frame counter response");
                check_count(data[15:0], 16'(frame), "frame counter");
                check_data(data & 32'hffff_0000, 32'h0, "frame word upper bits");
            end
            default: begin
                check_resp(resp, SLVERR, "unmapped response");
                check_data(data, 32'h0, "unmapped data");
            end
        endcase
    endtask

    // Counter may only sit one below the target while polling
    task automatic wait_for_frame(input int frame);
        logic [31:0] data;
        axil_resp_e  resp;
        do begin
            axi_read(`SNES_ADDR_FRAMES, data, resp);
            check_resp(resp, OKAY, "frame counter response");
            if (data[15:0] != 16'(frame)) begin
                check_count(data[15:0], 16'(frame - 1), "frame counter before commit");
            end
        end while (data[15:0] != 16'(frame));
        check_count(data[15:0], 16'(latch_rises), "frame counter against latch pulses");
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------

    initial begin
        logic [31:0] pick;
        aresetn = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        for (int n = 0; n < N_WORDS; n++) begin
            words0[n] = 16'(rand_bits(16));
            words1[n] = 16'(rand_bits(16));
            // Frame 3 all pressed, frame 5 none
            if (n == 3) begin
                words0[n][`SNES_BTNS-1:0] = '0;
                words1[n][`SNES_BTNS-1:0] = '0;
            end
            if (n == 5) begin
                words0[n][`SNES_BTNS-1:0] = '1;
                words1[n][`SNES_BTNS-1:0] = '1;
            end
            if (n == 0) begin
                exp0[n].raw = '0;
                exp1[n].raw = '0;
            end else begin
                exp0[n].raw = ~words0[n][`SNES_BTNS-1:0];
                exp1[n].raw = ~words1[n][`SNES_BTNS-1:0];
            end
        end
        repeat (2) @(negedge clk);
        aresetn = 1'b1;
        check_read(`SNES_ADDR_PADS, 0);
        check_read(`SNES_ADDR_FRAMES, 0);
        for (int f = 1; f <= N_FRAMES; f++) begin
            wait_for_frame(f);
            if (f == 2) begin
                check_read(4'h8, f);
                check_read(4'hc, f);
            end
            check_read(`SNES_ADDR_PADS, f);
            pick = rand_bits(2);
            check_read({pick[1:0], 2'b00}, f);
        end
        $display("All checks passed");
        $finish;
    end

    initial begin
        #((N_FRAMES + 4) * `SNES_POLL_CLKS * 8);
        abort_run("Timeout: the frames did not complete in the expected time");
    end

endmodule

`default_nettype wire

//--- dv/snes_pad_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "snes_params.svh"

module snes_pad_model (
    input  wire                  latch,
    input  wire                  pad_clk,
    input  wire [`SNES_BITS-1:0] word,
    output logic                 data
);

    // Idle line is high with nothing pressed
    logic [`SNES_BITS-1:0] shift_q = '1;

    // --------------------------------------------------
    // Parallel load and serial shift
    // --------------------------------------------------

    // Load while latched, so bit 0 is on the wire at once
    always @(posedge latch or posedge pad_clk) begin
        if (latch) begin
            shift_q <= word;
        end else begin
            shift_q <= {1'b1, shift_q[`SNES_BITS-1:1]};
        end
    end

    assign data = shift_q[0];

endmodule

`default_nettype wire

//--- logic/snes_reader.sv
`timescale 1ns/1ps
`default_nettype none

module snes_reader (
    input  wire         clk,
    input  wire         aresetn,

    // AXI-Lite read address
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,

    // AXI-Lite read data
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,

    // Pads, latch and clock shared
    output logic        pad_latch,
    output logic        pad_clk,
    input  logic        pad0_data,
    input  logic        pad1_data
);

    import snes_pkg::*;

    logic         sample;
    logic         commit;
    pad_buttons_u pad0_btns;
    pad_buttons_u pad1_btns;

    // --------------------------------------------------
    // Poll frame timing
    // --------------------------------------------------

    pad_sequencer u_seq (
        .clk       (clk),
        .aresetn   (aresetn),
        .pad_latch (pad_latch),
        .pad_clk   (pad_clk),
        .sample    (sample),
        .commit    (commit)
    );

    // --------------------------------------------------
    // One shifter per pad
    // --------------------------------------------------

    pad_shifter u_pad0 (
        .clk     (clk),
        .aresetn (aresetn),
        .data    (pad0_data),
        .sample  (sample),
        .commit  (commit),
        .buttons (pad0_btns)
    );

    pad_shifter u_pad1 (
        .clk     (clk),
        .aresetn (aresetn),
        .data    (pad1_data),
        .sample  (sample),
        .commit  (commit),
        .buttons (pad1_btns)
    );

    // --------------------------------------------------
    // Register block
    // --------------------------------------------------

    button_regs u_regs (
        .clk     (clk),
        .aresetn (aresetn),
        .commit  (commit),
        .pad0    (pad0_btns),
        .pad1    (pad1_btns),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

endmodule

`default_nettype wire

//--- logic/button_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "snes_params.svh"

module button_regs (
    input  wire                    clk,
    input  wire                    aresetn,
    input  logic                   commit,
    input  snes_pkg::pad_buttons_u pad0,
    input  snes_pkg::pad_buttons_u pad1,
    input  logic [3:0]             araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [31:0]            rdata,
    output snes_pkg::axil_resp_e   rresp,
    output logic                   rvalid,
    input  logic                   rready
);

    import snes_pkg::*;

    localparam int PAD_PAD_W = 32 - 2 * `SNES_BTNS;

    logic         commit_q;
    pad_buttons_u pad0_q;
    pad_buttons_u pad1_q;
    logic [15:0]  frames_q;

    logic         ar_fire;
    logic         r_fire;
    logic [31:0]  rdata_d;
    axil_resp_e   rresp_d;

    // --------------------------------------------------
    // Snapshot store
    // --------------------------------------------------

    // Shifters present their new snapshot one cycle after commit
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            commit_q <= 1'b0;
            pad0_q   <= '0;
            pad1_q   <= '0;
            frames_q <= '0;
        end else begin
            commit_q <= commit;
            if (commit_q) begin
                pad0_q   <= pad0;
                pad1_q   <= pad1;
                frames_q <= frames_q + 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Address decode
    // --------------------------------------------------

    always_comb begin
        rdata_d = '0;
        rresp_d = SLVERR;
        case (araddr)
            `SNES_ADDR_PADS: begin
                rdata_d = {{PAD_PAD_W{1'b0}}, pad1_q.raw, pad0_q.raw};
                rresp_d = OKAY;
            end
            `SNES_ADDR_FRAMES: begin
                rdata_d = {16'd0, frames_q};
                rresp_d = OKAY;
            end
            default: begin
                rdata_d = '0;
                rresp_d = SLVERR;
            end
        endcase
    end

    // --------------------------------------------------
    // Read handshake
    // --------------------------------------------------

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    // One read in flight; AR is closed while R is pending
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            rvalid  <= 1'b0;
            arready <= 1'b0;
        end else if (ar_fire) begin
            rvalid  <= 1'b1;
            arready <= 1'b0;
        end else if (r_fire) begin
            rvalid  <= 1'b0;
            arready <= 1'b1;
        end else begin
            arready <= !rvalid;
        end
    end

    // Held stable while the master stalls
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rdata <= rdata_d;
            rresp <= rresp_d;
        end
    end

endmodule

`default_nettype wire

//--- logic/pad_shifter.sv
`timescale 1ns/1ps
`default_nettype none

`include "snes_params.svh"

module pad_shifter (
    input  wire                  clk,
    input  wire                  aresetn,
    input  logic                 data,
    input  logic                 sample,
    input  logic                 commit,
    output snes_pkg::pad_buttons_u buttons
);

    logic [`SNES_BITS-1:0] shift_q;

    // --------------------------------------------------
    // Serial capture
    // --------------------------------------------------

    // Pad data is active low; first bit ends up in position 0
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            shift_q <= '0;
        end else if (commit) begin
            shift_q <= '0;
        end else if (sample) begin
            shift_q <= {~data, shift_q[`SNES_BITS-1:1]};
        end
    end

    // --------------------------------------------------
    // Snapshot
    // --------------------------------------------------

    // Upper bits carry no buttons and are dropped
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            buttons.raw <= '0;
        end else if (commit) begin
            buttons.raw <= shift_q[`SNES_BTNS-1:0];
        end
    end

endmodule

`default_nettype wire

//--- logic/pad_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "snes_params.svh"

module pad_sequencer (
    input  wire  clk,
    input  wire  aresetn,
    output logic pad_latch,
    output logic pad_clk,
    output logic sample,
    output logic commit
);

    localparam int FRAME_W = $clog2(`SNES_POLL_CLKS);
    localparam int PHASE_W = (`SNES_HALF_CLKS > 1) ? $clog2(`SNES_HALF_CLKS) : 1;
    localparam int HALF_W  = $clog2(2 * `SNES_BITS + 3);

    localparam logic [FRAME_W-1:0] FRAME_LAST = FRAME_W'(`SNES_POLL_CLKS - 1);
    localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(`SNES_HALF_CLKS - 1);

    // Half periods 0 and 1 are the latch, then two per bit
    localparam logic [HALF_W-1:0] DATA_FIRST = HALF_W'(2);
    localparam logic [HALF_W-1:0] DATA_END   = HALF_W'(2 + 2 * `SNES_BITS);
    localparam logic [HALF_W-1:0] SAMPLE_END = HALF_W'(2 * `SNES_BITS);

    logic [FRAME_W-1:0] frame_cnt;
    logic [PHASE_W-1:0] phase;
    logic [HALF_W-1:0]  half;

    logic latch_d;
    logic pad_clk_d;
    logic sample_d;
    logic commit_d;

    // --------------------------------------------------
    // Frame position
    // --------------------------------------------------

    // Counters hold the position of the cycle being prepared
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            frame_cnt <= '0;
            phase     <= '0;
            half      <= '0;
        end else if (frame_cnt == FRAME_LAST) begin
            frame_cnt <= '0;
            phase     <= '0;
            half      <= '0;
        end else begin
            frame_cnt <= frame_cnt + 1'b1;
            if (phase == PHASE_LAST) begin
                phase <= '0;
                // Saturates in the idle tail of long frames
                if (half != '1) begin
                    half <= half + 1'b1;
                end
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Decode
    // --------------------------------------------------

    always_comb begin
        latch_d   = (half < DATA_FIRST);
        // Even half periods in the data window are low
        pad_clk_d = !((half >= DATA_FIRST) && (half < DATA_END) && !half[0]);
        // Last cycle of each odd half period including the final latch half
        sample_d  = (phase == PHASE_LAST) && half[0] && (half < SAMPLE_END);
        commit_d  = (phase == '0) && (half == SAMPLE_END);
    end

    // Registered so the pads see clean edges
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            pad_latch <= 1'b0;
            pad_clk   <= 1'b1;
            sample    <= 1'b0;
            commit    <= 1'b0;
        end else begin
            pad_latch <= latch_d;
            pad_clk   <= pad_clk_d;
            sample    <= sample_d;
            commit    <= commit_d;
        end
    end

endmodule

`default_nettype wire

//--- logic/snes_pkg.sv
`default_nettype none

`include "snes_params.svh"

package snes_pkg;

    // Button order matches shift order with b first
    typedef struct packed {
        logic r;
        logic l;
        logic x;
        logic a;
        logic right;
        logic left;
        logic down;
        logic up;
        logic start;
        logic select;
        logic y;
        logic b;
    } pad_buttons_t;

    // Set bit means pressed
    typedef union packed {
        logic [`SNES_BTNS-1:0] raw;
        pad_buttons_t          named;
    } pad_buttons_u;

    // AXI read response codes in use
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

endpackage

`default_nettype wire

//--- logic/snes_params.svh
`ifndef SNES_PARAMS_SVH
`define SNES_PARAMS_SVH

// --------------------------------------------------
// Pad timing
// --------------------------------------------------

// clk cycles per pad clock half period and per latch half
`define SNES_HALF_CLKS 4

// clk cycles from one frame start to the next
// Must exceed the frame, which is (2 + 2 * SNES_BITS) half periods plus commit
`define SNES_POLL_CLKS 200

// Bits shifted out of a pad per frame
`define SNES_BITS 16

// Buttons kept from each frame
`define SNES_BTNS 12

// --------------------------------------------------
// Register map (byte addresses)
// --------------------------------------------------

// Both pads with pad0 in the low field
`define SNES_ADDR_PADS 4'h0

// Completed frame count
`define SNES_ADDR_FRAMES 4'h4

`endif
